/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_read_reorder_monitor
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/ar_issue_tracker.sv */
// ####################################################################
// records every master read request in the queue of its slave
// slave chosen by one address bit, no address map
// route strobe is combinational with the master AR handshake
// ####################################################################
module ar_issue_tracker (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        mst_ar_valid_i,
  input  logic                                        mst_ar_ready_i,
  input  reorder_pkg::id_t                            mst_ar_id_i,
  input  reorder_pkg::addr_t                          mst_ar_addr_i,
  input  reorder_pkg::len_t                           mst_ar_len_i,
  input  reorder_pkg::slv_mask_t                      exp_pop_i,
  output reorder_pkg::slv_mask_t                      exp_valid_o,
  output reorder_pkg::id_t   [reorder_pkg::SLV_NUM-1:0] exp_id_o,
  output reorder_pkg::addr_t [reorder_pkg::SLV_NUM-1:0] exp_addr_o,
  output reorder_pkg::len_t  [reorder_pkg::SLV_NUM-1:0] exp_len_o,
  output logic                                        route_push_o,
  output reorder_pkg::id_t                            route_id_o,
  output reorder_pkg::slv_idx_t                       route_slv_o,
  output logic                                        idle_o
);
  import reorder_pkg::*;

  logic      ar_evt;
  slv_idx_t  ar_slv;
  slv_mask_t exp_empty;

  assign ar_evt = mst_ar_valid_i & mst_ar_ready_i;
  assign ar_slv = mst_ar_addr_i[SLV_SEL_LSB];

  // expected requests per slave, in issue order
  for (genvar s = 0; s < SLV_NUM; s++) begin : gen_exp
    order_fifo #(
      .WIDTH(ID_W + ADDR_W + LEN_W)
    ) u_exp_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .push_i  (ar_evt && (ar_slv == slv_idx_t'(s))),
      .data_i  ({mst_ar_id_i, mst_ar_addr_i, mst_ar_len_i}),
      .pop_i   (exp_pop_i[s]),
      .data_o  ({exp_id_o[s], exp_addr_o[s], exp_len_o[s]}),
      .empty_o (exp_empty[s]),
      .full_o  ()
    );

    assign exp_valid_o[s] = !exp_empty[s];
  end

  // order checker learns which slave answers this ID
  assign route_push_o = ar_evt;
  assign route_id_o   = mst_ar_id_i;
  assign route_slv_o  = ar_slv;

  assign idle_o = &exp_empty;

endmodule

/* design/order_fifo.sv */
// ####################################################################
// small first-in first-out store with a head that is always visible
// push to a full store or pop of an empty one is not allowed
// push and pop in the same cycle are fine
// ####################################################################
module order_fifo #(
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);
  import reorder_pkg::*;

  logic [WIDTH-1:0]                mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count_q;

  // pointers wrap on their own width
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  // top count bit is set only at FIFO_DEPTH
  assign full_o  = count_q[$clog2(FIFO_DEPTH)];

endmodule

/* design/r_order_checker.sv */
// ####################################################################
// compares master read beats with the beats the slaves returned
// per ID the route queue names the slave of the oldest read
// reorder across IDs is legal, within one ID it is an error
// mismatching beats are still consumed so the queues drain
// ####################################################################
module r_order_checker (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  logic                                                 route_push_i,
  input  reorder_pkg::id_t                                     route_id_i,
  input  reorder_pkg::slv_idx_t                                route_slv_i,
  input  logic                                                 mst_r_valid_i,
  input  logic                                                 mst_r_ready_i,
  input  reorder_pkg::id_t                                     mst_r_id_i,
  input  reorder_pkg::data_t                                   mst_r_data_i,
  input  logic                                                 mst_r_last_i,
  input  reorder_pkg::id_mask_t [reorder_pkg::SLV_NUM-1:0]     beat_valid_i,
  input  reorder_pkg::data_t
         [reorder_pkg::SLV_NUM-1:0][reorder_pkg::ID_NUM-1:0]   beat_data_i,
  input  reorder_pkg::id_mask_t [reorder_pkg::SLV_NUM-1:0]     beat_last_i,
  output reorder_pkg::id_mask_t [reorder_pkg::SLV_NUM-1:0]     beat_pop_o,
  output logic                                                 r_mismatch_o,
  output logic                                                 r_unexpected_o,
  output logic                                                 idle_o
);
  import reorder_pkg::*;

  logic                  r_evt;
  id_mask_t              route_empty;
  slv_idx_t [ID_NUM-1:0] route_head;
  slv_idx_t              sel_slv;
  logic                  beat_ok;
  data_t                 exp_data;
  logic                  exp_last;

  assign r_evt = mst_r_valid_i & mst_r_ready_i;

  // one route queue per ID
  for (genvar i = 0; i < ID_NUM; i++) begin : gen_route
    order_fifo #(
      .WIDTH($bits(slv_idx_t))
    ) u_route_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .push_i  (route_push_i && (route_id_i == id_t'(i))),
      .data_i  (route_slv_i),
      .pop_i   (r_evt && beat_ok && mst_r_last_i && (mst_r_id_i == id_t'(i))),
      .data_o  (route_head[i]),
      .empty_o (route_empty[i]),
      .full_o  ()
    );
  end

  assign sel_slv  = route_head[mst_r_id_i];
  assign exp_data = beat_data_i[sel_slv][mst_r_id_i];
  assign exp_last = beat_last_i[sel_slv][mst_r_id_i];
  // need a route and a stored beat from the routed slave
  assign beat_ok  = !route_empty[mst_r_id_i] && beat_valid_i[sel_slv][mst_r_id_i];

  always_comb begin
    beat_pop_o = '0;
    if (r_evt && beat_ok) begin
      beat_pop_o[sel_slv][mst_r_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_mismatch_o   <= 1'b0;
      r_unexpected_o <= 1'b0;
    end else begin
      r_mismatch_o   <= r_evt && beat_ok &&
                        ((exp_data != mst_r_data_i) || (exp_last != mst_r_last_i));
      r_unexpected_o <= r_evt && !beat_ok;
    end
  end

  assign idle_o = &route_empty;

endmodule

/* design/read_reorder_monitor.sv */
// ####################################################################
// read-order monitor for one master and two slave ports
// observes only, never drives ready or valid
// error outputs are one-cycle strobes one clock after the event
// idle is high when no read is outstanding anywhere
// ####################################################################
module read_reorder_monitor (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          mst_ar_valid_i,
  input  logic                                          mst_ar_ready_i,
  input  reorder_pkg::id_t                              mst_ar_id_i,
  input  reorder_pkg::addr_t                            mst_ar_addr_i,
  input  reorder_pkg::len_t                             mst_ar_len_i,
  input  logic                                          mst_r_valid_i,
  input  logic                                          mst_r_ready_i,
  input  reorder_pkg::id_t                              mst_r_id_i,
  input  reorder_pkg::data_t                            mst_r_data_i,
  input  logic                                          mst_r_last_i,
  input  reorder_pkg::slv_mask_t                        slv_ar_valid_i,
  input  reorder_pkg::slv_mask_t                        slv_ar_ready_i,
  input  reorder_pkg::addr_t [reorder_pkg::SLV_NUM-1:0] slv_ar_addr_i,
  input  reorder_pkg::len_t  [reorder_pkg::SLV_NUM-1:0] slv_ar_len_i,
  input  reorder_pkg::slv_mask_t                        slv_r_valid_i,
  input  reorder_pkg::slv_mask_t                        slv_r_ready_i,
  input  reorder_pkg::data_t [reorder_pkg::SLV_NUM-1:0] slv_r_data_i,
  input  reorder_pkg::slv_mask_t                        slv_r_last_i,
  output reorder_pkg::slv_mask_t                        ar_mismatch_o,
  output reorder_pkg::slv_mask_t                        ar_unexpected_o,
  output reorder_pkg::slv_mask_t                        slv_r_unexpected_o,
  output logic                                          r_mismatch_o,
  output logic                                          r_unexpected_o,
  output logic                                          idle_o
);
  import reorder_pkg::*;

  slv_mask_t                         exp_valid;
  id_t   [SLV_NUM-1:0]               exp_id;
  addr_t [SLV_NUM-1:0]               exp_addr;
  len_t  [SLV_NUM-1:0]               exp_len;
  slv_mask_t                         exp_pop;
  logic                              route_push;
  id_t                               route_id;
  slv_idx_t                          route_slv;
  id_mask_t [SLV_NUM-1:0]            beat_valid;
  data_t    [SLV_NUM-1:0][ID_NUM-1:0] beat_data;
  id_mask_t [SLV_NUM-1:0]            beat_last;
  id_mask_t [SLV_NUM-1:0]            beat_pop;
  logic                              trk_idle;
  slv_mask_t                         slv_idle;
  logic                              ord_idle;

  ar_issue_tracker u_tracker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .mst_ar_valid_i(mst_ar_valid_i),
    .mst_ar_ready_i(mst_ar_ready_i),
    .mst_ar_id_i   (mst_ar_id_i),
    .mst_ar_addr_i (mst_ar_addr_i),
    .mst_ar_len_i  (mst_ar_len_i),
    .exp_pop_i     (exp_pop),
    .exp_valid_o   (exp_valid),
    .exp_id_o      (exp_id),
    .exp_addr_o    (exp_addr),
    .exp_len_o     (exp_len),
    .route_push_o  (route_push),
    .route_id_o    (route_id),
    .route_slv_o   (route_slv),
    .idle_o        (trk_idle)
  );

  for (genvar s = 0; s < SLV_NUM; s++) begin : gen_slv
    slave_read_checker u_checker (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .ar_valid_i     (slv_ar_valid_i[s]),
      .ar_ready_i     (slv_ar_ready_i[s]),
      .ar_addr_i      (slv_ar_addr_i[s]),
      .ar_len_i       (slv_ar_len_i[s]),
      .r_valid_i      (slv_r_valid_i[s]),
      .r_ready_i      (slv_r_ready_i[s]),
      .r_data_i       (slv_r_data_i[s]),
      .r_last_i       (slv_r_last_i[s]),
      .exp_valid_i    (exp_valid[s]),
      .exp_id_i       (exp_id[s]),
      .exp_addr_i     (exp_addr[s]),
      .exp_len_i      (exp_len[s]),
      .exp_pop_o      (exp_pop[s]),
      .beat_valid_o   (beat_valid[s]),
      .beat_data_o    (beat_data[s]),
      .beat_last_o    (beat_last[s]),
      .beat_pop_i     (beat_pop[s]),
      .ar_mismatch_o  (ar_mismatch_o[s]),
      .ar_unexpected_o(ar_unexpected_o[s]),
      .r_unexpected_o (slv_r_unexpected_o[s]),
      .idle_o         (slv_idle[s])
    );
  end

  r_order_checker u_order (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .route_push_i  (route_push),
    .route_id_i    (route_id),
    .route_slv_i   (route_slv),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_i (mst_r_ready_i),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_last_i  (mst_r_last_i),
    .beat_valid_i  (beat_valid),
    .beat_data_i   (beat_data),
    .beat_last_i   (beat_last),
    .beat_pop_o    (beat_pop),
    .r_mismatch_o  (r_mismatch_o),
    .r_unexpected_o(r_unexpected_o),
    .idle_o        (ord_idle)
  );

  assign idle_o = trk_idle & (&slv_idle) & ord_idle;

endmodule

/* design/reorder_pkg.sv */
// ####################################################################
// shared widths, sizes and types of the read-order monitor
// queue depth must stay a power of two for the pointer wrap
// slave routing is one address bit, so only two slaves are decoded
// ####################################################################
package reorder_pkg;

  // slave ports behind the fabric
  localparam int unsigned SLV_NUM = 2;

  localparam int unsigned ID_W   = 2;
  localparam int unsigned ID_NUM = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // beats minus one, as on the bus
  localparam int unsigned LEN_W  = 8;

  // entries per queue, outstanding items never exceed this
  localparam int unsigned FIFO_DEPTH = 4;

  // bit set routes to slave 1, clear to slave 0
  localparam int unsigned SLV_SEL_LSB = 12;

  typedef logic [ID_W-1:0]    id_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [LEN_W-1:0]   len_t;
  typedef logic [0:0]         slv_idx_t;
  typedef logic [SLV_NUM-1:0] slv_mask_t;
  typedef logic [ID_NUM-1:0]  id_mask_t;

endpackage

/* design/slave_read_checker.sv */
// ####################################################################
// checks one slave port against the requests issued for it
// slave AR ID is ignored since the fabric may rewrite it
// R beats are tagged with the oldest accepted master ID
// a request that mismatches is dropped and gets no ID entry
// ####################################################################
module slave_read_checker (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  logic                                           ar_valid_i,
  input  logic                                           ar_ready_i,
  input  reorder_pkg::addr_t                             ar_addr_i,
  input  reorder_pkg::len_t                              ar_len_i,
  input  logic                                           r_valid_i,
  input  logic                                           r_ready_i,
  input  reorder_pkg::data_t                             r_data_i,
  input  logic                                           r_last_i,
  input  logic                                           exp_valid_i,
  input  reorder_pkg::id_t                               exp_id_i,
  input  reorder_pkg::addr_t                             exp_addr_i,
  input  reorder_pkg::len_t                              exp_len_i,
  output logic                                           exp_pop_o,
  output reorder_pkg::id_mask_t                          beat_valid_o,
  output reorder_pkg::data_t [reorder_pkg::ID_NUM-1:0]   beat_data_o,
  output reorder_pkg::id_mask_t                          beat_last_o,
  input  reorder_pkg::id_mask_t                          beat_pop_i,
  output logic                                           ar_mismatch_o,
  output logic                                           ar_unexpected_o,
  output logic                                           r_unexpected_o,
  output logic                                           idle_o
);
  import reorder_pkg::*;

  logic     ar_evt;
  logic     r_evt;
  logic     ar_match;
  logic     id_empty;
  id_t      id_head;
  id_mask_t beat_push;
  id_mask_t beat_empty;

  assign ar_evt = ar_valid_i & ar_ready_i;
  assign r_evt  = r_valid_i & r_ready_i;

  assign ar_match  = (ar_addr_i == exp_addr_i) && (ar_len_i == exp_len_i);
  assign exp_pop_o = ar_evt & exp_valid_i;

  // master IDs of accepted requests, oldest first
  order_fifo #(
    .WIDTH(ID_W)
  ) u_id_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .push_i  (exp_pop_o & ar_match),
    .data_i  (exp_id_i),
    .pop_i   (r_evt & !id_empty & r_last_i),
    .data_o  (id_head),
    .empty_o (id_empty),
    .full_o  ()
  );

  // beats sorted by the master ID they belong to
  for (genvar i = 0; i < ID_NUM; i++) begin : gen_beat
    assign beat_push[i] = r_evt && !id_empty && (id_head == id_t'(i));

    order_fifo #(
      .WIDTH(DATA_W + 1)
    ) u_beat_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .push_i  (beat_push[i]),
      .data_i  ({r_data_i, r_last_i}),
      .pop_i   (beat_pop_i[i]),
      .data_o  ({beat_data_o[i], beat_last_o[i]}),
      .empty_o (beat_empty[i]),
      .full_o  ()
    );

    assign beat_valid_o[i] = !beat_empty[i];
  end

  // error strobes, one cycle after the handshake
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_mismatch_o   <= 1'b0;
      ar_unexpected_o <= 1'b0;
      r_unexpected_o  <= 1'b0;
    end else begin
      ar_mismatch_o   <= exp_pop_o & !ar_match;
      ar_unexpected_o <= ar_evt & !exp_valid_i;
      // beat without an accepted request is dropped
      r_unexpected_o  <= r_evt & id_empty;
    end
  end

  assign idle_o = id_empty & (&beat_empty);

endmodule

/* project.f */
design/reorder_pkg.sv
design/order_fifo.sv
design/ar_issue_tracker.sv
design/slave_read_checker.sv
design/r_order_checker.sv
design/read_reorder_monitor.sv
sim/read_reorder_monitor_assert.sv
sim/tb_read_reorder_monitor.sv

/* sim/monitor_trace.txt */
// mar mid maddr mlen  mr rid rdata rlast  sarv sarr saddr slen  srv srr sdata slast (mar, mr = valid,ready)
// then expected one clock later: ar_mismatch ar_unexpected slv_r_unexpected r_mismatch r_unexpected idle
// in-order two-beat reads to both slaves
3 0 0100 1   0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0 0 0 0
3 1 1100 1   0 0 0000 0   1 1 0100 1   0 0 0000 0   0 0 0 0 0 0
0 0 0000 0   0 0 0000 0   2 2 1100 1   1 1 a000 0   0 0 0 0 0 0
0 0 0000 0   3 0 a000 0   0 0 0000 0   1 1 a001 1   0 0 0 0 0 0
0 0 0000 0   3 0 a001 1   0 0 0000 0   2 2 b000 0   0 0 0 0 0 0
0 0 0000 0   3 1 b000 0   0 0 0000 0   2 2 b001 2   0 0 0 0 0 0
0 0 0000 0   3 1 b001 1   0 0 0000 0   0 0 0000 0   0 0 0 0 0 1
// IDs 0 and 1 answered to the master in swapped order
3 0 0200 0   0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0 0 0 0
3 1 1200 0   0 0 0000 0   1 1 0200 0   0 0 0000 0   0 0 0 0 0 0
0 0 0000 0   0 0 0000 0   2 2 1200 0   1 1 c000 1   0 0 0 0 0 0
0 0 0000 0   0 0 0000 0   0 0 0000 0   2 2 d000 2   0 0 0 0 0 0
0 0 0000 0   3 1 d000 1   0 0 0000 0   0 0 0000 0   0 0 0 0 0 0
0 0 0000 0   3 0 c000 1   0 0 0000 0   0 0 0000 0   0 0 0 0 0 1
// two ID 2 reads, slave 1 data reaches the master first
3 2 0300 0   0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0 0 0 0
3 2 1300 0   0 0 0000 0   1 1 0300 0   0 0 0000 0   0 0 0 0 0 0
0 0 0000 0   0 0 0000 0   2 2 1300 0   1 1 e000 1   0 0 0 0 0 0
2 0 0100 0   0 0 0000 0   0 0 0000 0   2 2 f000 2   0 0 0 0 0 0
0 0 0000 0   3 2 f000 1   0 0 0000 0   0 0 0000 0   0 0 0 1 0 0
0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0 0 0 0
0 0 0000 0   3 2 e000 1   0 0 0000 0   0 0 0000 0   0 0 0 1 0 1
// wrong slave address, stray requests and beats, then drain of ID 3
3 3 1400 0   0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0 0 0 0
0 0 0000 0   0 0 0000 0   2 2 1480 0   0 0 0000 0   2 0 0 0 0 0
3 3 1400 0   0 0 0000 0   1 1 0500 0   0 0 0000 0   0 1 0 0 0 0
0 0 0000 0   3 1 0000 1   2 2 1400 0   1 1 9000 1   0 0 1 0 1 0
0 0 0000 0   2 2 0000 0   0 0 0000 0   2 2 9300 0   0 0 0 0 0 0
0 0 0000 0   3 3 9300 1   0 0 0000 0   2 2 9301 2   0 0 0 1 0 0
0 0 0000 0   3 3 9301 1   0 0 0000 0   0 0 0000 0   0 0 0 0 0 1
0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0000 0   0 0 0 0 0 1

/* sim/read_reorder_monitor_assert.sv */
// ####################################################################
// bound checks for the read-order monitor
// bound to every queue for push and pop rules
// bound to the top for the one-cycle shape of the error strobes
// unused inputs of each binding are tied to quiet values
// ####################################################################
module read_reorder_monitor_assert #(
  parameter int unsigned STROBE_W = 8
) (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                push_i,
  input logic                pop_i,
  input logic                full_i,
  input logic                empty_i,
  input logic [STROBE_W-1:0] strobe_i
);
  timeunit 1ns;
  timeprecision 100ps;

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_i))
    else $error("push to a full queue");

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(pop_i && empty_i))
    else $error("pop of an empty queue");

  // each strobe bit is high for one cycle at most
  strobe_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (strobe_i & $past(strobe_i)) == '0)
    else $error("error strobe high two cycles in a row");

endmodule

bind order_fifo read_reorder_monitor_assert u_fifo_assert (
  .clk_i   (clk_i),
  .arst_n_i(arst_n_i),
  .push_i  (push_i),
  .pop_i   (pop_i),
  .full_i  (full_o),
  .empty_i (empty_o),
  .strobe_i('0)
);

bind read_reorder_monitor read_reorder_monitor_assert u_strobe_assert (
  .clk_i   (clk_i),
  .arst_n_i(arst_n_i),
  .push_i  (1'b0),
  .pop_i   (1'b0),
  .full_i  (1'b0),
  .empty_i (1'b1),
  .strobe_i({ar_mismatch_o, ar_unexpected_o, slv_r_unexpected_o, r_mismatch_o, r_unexpected_o})
);

/* sim/tb_read_reorder_monitor.sv */
// ####################################################################
// testbench for the read-order monitor
// stimulus and expected outputs come from sim/monitor_trace.txt
// one trace line per cycle, its outputs are checked one clock later
// slave AR address, length and R data are shared by both slave ports
// the run stops at the first wrong value or timeout
// ####################################################################
module tb_read_reorder_monitor;
  timeunit 1ns;
  timeprecision 100ps;
  import reorder_pkg::*;

  // 16 input words, then 6 expected output words
  localparam int unsigned LINE_WORDS   = 22;
  localparam int unsigned EXP_OFFSET   = 16;
  localparam int unsigned TRACE_LINES  = 28;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned IDLE_TIMEOUT = 64;

  logic                  clk;
  logic                  arst_n;
  logic                  mst_ar_valid;
  logic                  mst_ar_ready;
  id_t                   mst_ar_id;
  addr_t                 mst_ar_addr;
  len_t                  mst_ar_len;
  logic                  mst_r_valid;
  logic                  mst_r_ready;
  id_t                   mst_r_id;
  data_t                 mst_r_data;
  logic                  mst_r_last;
  slv_mask_t             slv_ar_valid;
  slv_mask_t             slv_ar_ready;
  addr_t [SLV_NUM-1:0]   slv_ar_addr;
  len_t  [SLV_NUM-1:0]   slv_ar_len;
  slv_mask_t             slv_r_valid;
  slv_mask_t             slv_r_ready;
  data_t [SLV_NUM-1:0]   slv_r_data;
  slv_mask_t             slv_r_last;
  slv_mask_t             ar_mismatch;
  slv_mask_t             ar_unexpected;
  slv_mask_t             slv_r_unexpected;
  logic                  r_mismatch;
  logic                  r_unexpected;
  logic                  idle;

  logic [31:0] trace_mem [TRACE_LINES*LINE_WORDS];

  read_reorder_monitor u_dut (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .mst_ar_valid_i    (mst_ar_valid),
    .mst_ar_ready_i    (mst_ar_ready),
    .mst_ar_id_i       (mst_ar_id),
    .mst_ar_addr_i     (mst_ar_addr),
    .mst_ar_len_i      (mst_ar_len),
    .mst_r_valid_i     (mst_r_valid),
    .mst_r_ready_i     (mst_r_ready),
    .mst_r_id_i        (mst_r_id),
    .mst_r_data_i      (mst_r_data),
    .mst_r_last_i      (mst_r_last),
    .slv_ar_valid_i    (slv_ar_valid),
    .slv_ar_ready_i    (slv_ar_ready),
    .slv_ar_addr_i     (slv_ar_addr),
    .slv_ar_len_i      (slv_ar_len),
    .slv_r_valid_i     (slv_r_valid),
    .slv_r_ready_i     (slv_r_ready),
    .slv_r_data_i      (slv_r_data),
    .slv_r_last_i      (slv_r_last),
    .ar_mismatch_o     (ar_mismatch),
    .ar_unexpected_o   (ar_unexpected),
    .slv_r_unexpected_o(slv_r_unexpected),
    .r_mismatch_o      (r_mismatch),
    .r_unexpected_o    (r_unexpected),
    .idle_o            (idle)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic end_with_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_slv_mask(input string what, input slv_mask_t got,
                                input slv_mask_t exp);
    if (got !== exp) begin
      $display("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_outputs(input string where, input slv_mask_t exp_ar_mis,
                               input slv_mask_t exp_ar_unx, input slv_mask_t exp_slv_unx,
                               input logic exp_r_mis, input logic exp_r_unx,
                               input logic exp_idle);
    check_slv_mask({where, " ar_mismatch_o"}, ar_mismatch, exp_ar_mis);
    check_slv_mask({where, " ar_unexpected_o"}, ar_unexpected, exp_ar_unx);
    check_slv_mask({where, " slv_r_unexpected_o"}, slv_r_unexpected, exp_slv_unx);
    check_flag({where, " r_mismatch_o"}, r_mismatch, exp_r_mis);
    check_flag({where, " r_unexpected_o"}, r_unexpected, exp_r_unx);
    check_flag({where, " idle_o"}, idle, exp_idle);
  endtask

  task automatic check_line(input int unsigned line);
    int unsigned b;
    b = line * LINE_WORDS + EXP_OFFSET;
    check_outputs($sformatf("trace line %0d", line),
                  slv_mask_t'(trace_mem[b]), slv_mask_t'(trace_mem[b+1]),
                  slv_mask_t'(trace_mem[b+2]), trace_mem[b+3][0],
                  trace_mem[b+4][0], trace_mem[b+5][0]);
  endtask

  task automatic drive_quiet();
    mst_ar_valid = 1'b0;
    mst_ar_ready = 1'b0;
    mst_ar_id    = '0;
    mst_ar_addr  = '0;
    mst_ar_len   = '0;
    mst_r_valid  = 1'b0;
    mst_r_ready  = 1'b0;
    mst_r_id     = '0;
    mst_r_data   = '0;
    mst_r_last   = 1'b0;
    slv_ar_valid = '0;
    slv_ar_ready = '0;
    slv_ar_addr  = '0;
    slv_ar_len   = '0;
    slv_r_valid  = '0;
    slv_r_ready  = '0;
    slv_r_data   = '0;
    slv_r_last   = '0;
  endtask

  task automatic drive_line(input int unsigned line);
    int unsigned b;
    b = line * LINE_WORDS;
    // handshake words hold valid in bit 1 and ready in bit 0
    mst_ar_valid = trace_mem[b][1];
    mst_ar_ready = trace_mem[b][0];
    mst_ar_id    = id_t'(trace_mem[b+1]);
    mst_ar_addr  = addr_t'(trace_mem[b+2]);
    mst_ar_len   = len_t'(trace_mem[b+3]);
    mst_r_valid  = trace_mem[b+4][1];
    mst_r_ready  = trace_mem[b+4][0];
    mst_r_id     = id_t'(trace_mem[b+5]);
    mst_r_data   = data_t'(trace_mem[b+6]);
    mst_r_last   = trace_mem[b+7][0];
    slv_ar_valid = slv_mask_t'(trace_mem[b+8]);
    slv_ar_ready = slv_mask_t'(trace_mem[b+9]);
    slv_ar_addr  = {SLV_NUM{addr_t'(trace_mem[b+10])}};
    slv_ar_len   = {SLV_NUM{len_t'(trace_mem[b+11])}};
    slv_r_valid  = slv_mask_t'(trace_mem[b+12]);
    slv_r_ready  = slv_mask_t'(trace_mem[b+13]);
    slv_r_data   = {SLV_NUM{data_t'(trace_mem[b+14])}};
    slv_r_last   = slv_mask_t'(trace_mem[b+15]);
  endtask

  task automatic wait_for_idle(input string when_txt);
    int unsigned cycles;
    cycles = 0;
    while (idle !== 1'b1) begin
      if (cycles == IDLE_TIMEOUT) begin
        $display("timeout: idle_o stayed low %s", when_txt);
        end_with_failure();
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  initial begin
    arst_n = 1'b0;
    drive_quiet();
    $readmemh("sim/monitor_trace.txt", trace_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
    wait_for_idle("after reset");
    check_outputs("after reset", '0, '0, '0, 1'b0, 1'b0, 1'b1);

    // outputs of line n are stable from the edge that samples it
    for (int unsigned line = 0; line < TRACE_LINES; line++) begin
      @(posedge clk);
      #1;
      if (line > 0) begin
        check_line(line - 1);
      end
      drive_line(line);
    end
    @(posedge clk);
    #1;
    check_line(TRACE_LINES - 1);
    drive_quiet();
    wait_for_idle("after the trace");

    $display("TEST PASS");
    $finish;
  end

endmodule
